// File: Bender.yml
package:
  name: cpu_checker

sources:
  - src/checker_pkg.sv
  - src/cfg_pkg.sv
  - src/field_if.sv
  - src/char_classify.sv
  - src/record_parser.sv
  - src/rule_checker.sv
  - src/cpu_checker.sv
  - target: test
    files:
      - verif/tb_cpu_checker.sv

// File: compile.f
src/checker_pkg.sv
src/cfg_pkg.sv
src/field_if.sv
src/char_classify.sv
src/record_parser.sv
src/rule_checker.sv
src/cpu_checker.sv
verif/tb_cpu_checker.sv

// File: src/cfg_pkg.sv
package cfg_pkg;

  // field widths
  localparam int time_w = 16; // time and freq
  localparam int word_w = 32; // pc and addr
  localparam int reg_w  = 16; // decimal register field

  // text region for pc
  localparam logic [word_w-1:0] text_lo = 32'h0000_3000;
  localparam logic [word_w-1:0] text_hi = 32'h0000_4fff;

  // data region for memory writes
  localparam logic [word_w-1:0] data_lo = 32'h0000_0000;
  localparam logic [word_w-1:0] data_hi = 32'h0000_2fff;

  localparam logic [reg_w-1:0] reg_max = 16'd31;

  // pc, addr and data all use this many hex digits
  localparam int hex_digits = 8;

endpackage

// File: src/char_classify.sv
module char_classify
  import checker_pkg::*;
(
  input  logic [7:0]  char,
  output char_class_e char_class,
  output logic [3:0]  digit_val
);

  always_comb
  begin
    char_class = other;
    digit_val  = 4'd0;
    if (char >= "0" && char <= "9")
    begin
      char_class = dec_digit;
      digit_val  = char[3:0]; // low nibble of ascii digit
    end
    else if (char >= "a" && char <= "f")
    begin
      char_class = hex_letter;
      digit_val  = char[3:0] + 4'd9; // 'a' is 0x61
    end
    else
    begin
      case (char)
        "^":     char_class = caret;
        "@":     char_class = at_sign;
        ":":     char_class = colon;
        " ":     char_class = space;
        "$":     char_class = dollar;
        "*":     char_class = star;
        "<":     char_class = less;
        "=":     char_class = equal;
        "#":     char_class = hash;
        default: char_class = other;
      endcase
    end
  end

endmodule

// File: src/checker_pkg.sv
package checker_pkg;

  // parser position inside one trace record
  typedef enum logic [3:0] {
    idle,         // waiting for a caret
    time_digits,  // after ^
    pc_digits,    // after @
    kind_select,  // after the colon, spaces allowed
    target_field, // reg number or memory address
    arrow_eq,     // seen <, expecting =
    data_digits,  // spaces then eight hex digits
    reported      // record complete, one cycle
  } parse_state_e;

  // character classes, these drive the parser like opcodes
  typedef enum logic [3:0] {
    dec_digit,  // 0-9
    hex_letter, // a-f only
    caret,
    at_sign,
    colon,
    space,
    dollar,
    star,
    less,
    equal,
    hash,
    other       // anything else, upper case too
  } char_class_e;

  // report format seen at the top level
  typedef enum logic [1:0] {
    fmt_none = 2'd0,
    fmt_reg  = 2'd1,
    fmt_mem  = 2'd2
  } format_e;

endpackage

// File: src/cpu_checker.sv
module cpu_checker
  import checker_pkg::*;
  import cfg_pkg::*;
#(
  parameter int MAX_DEC_DIGITS = 4
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic [time_w-1:0] freq,
  input  logic [7:0]        char,
  output logic [1:0]        format_type,
  output logic [3:0]        error_code
);

  char_class_e char_class;
  logic [3:0]  digit_val;

  field_if rec ();

  char_classify u_classify (
    .char       (char),
    .char_class (char_class),
    .digit_val  (digit_val)
  );

  record_parser #(
    .MAX_DEC_DIGITS (MAX_DEC_DIGITS)
  ) u_parser (
    .clk        (clk),
    .reset      (reset),
    .char_class (char_class),
    .digit_val  (digit_val),
    .rec        (rec.producer)
  );

  rule_checker u_rules (
    .freq        (freq),
    .rec         (rec.consumer),
    .format_type (format_type),
    .error_code  (error_code)
  );

endmodule

// File: src/field_if.sv
interface field_if
  import cfg_pkg::*;
();

  logic              done;     // one cycle per accepted record
  logic              is_mem;   // 1 for *addr, 0 for $reg
  logic [time_w-1:0] time_val;
  logic [word_w-1:0] pc;
  logic [word_w-1:0] addr;
  logic [reg_w-1:0]  reg_num;

  modport producer (
    output done, is_mem, time_val, pc, addr, reg_num
  );

  modport consumer (
    input done, is_mem, time_val, pc, addr, reg_num
  );

endinterface

// File: src/record_parser.sv
module record_parser
  import checker_pkg::*;
  import cfg_pkg::*;
#(
  parameter int MAX_DEC_DIGITS = 4
)
(
  input  logic        clk,
  input  logic        reset,
  input  char_class_e char_class,
  input  logic [3:0]  digit_val,
  field_if.producer   rec
);

  localparam int cnt_w = $clog2(hex_digits + 1);
  localparam logic [cnt_w-1:0] dec_max = cnt_w'(MAX_DEC_DIGITS);
  localparam logic [cnt_w-1:0] hex_max = cnt_w'(hex_digits);

  parse_state_e state_q;
  parse_state_e state_d;
  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_d;
  logic spaced_q; // trailing spaces closed the target field
  logic spaced_d;
  logic is_mem_q;
  logic is_mem_d;

  logic [time_w-1:0] time_q;
  logic [word_w-1:0] pc_q;
  logic [word_w-1:0] addr_q;
  logic [reg_w-1:0]  reg_q;

  logic clear_fields;
  logic load_time;
  logic load_pc;
  logic load_addr;
  logic load_reg;

  logic is_hex;
  logic target_digit;
  logic [cnt_w-1:0] target_max;
  logic target_full;

  assign is_hex = (char_class == dec_digit) || (char_class == hex_letter);

  // register numbers are decimal, addresses hex
  assign target_digit = is_mem_q ? is_hex : (char_class == dec_digit);
  assign target_max   = is_mem_q ? hex_max : dec_max;
  assign target_full  = is_mem_q ? (cnt_q == hex_max) : (cnt_q != '0);

  always_comb
  begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    spaced_d     = spaced_q;
    is_mem_d     = is_mem_q;
    clear_fields = 1'b0;
    load_time    = 1'b0;
    load_pc      = 1'b0;
    load_addr    = 1'b0;
    load_reg     = 1'b0;
    if (char_class == caret)
    begin
      // restart from any state
      state_d      = time_digits;
      cnt_d        = '0;
      spaced_d     = 1'b0;
      clear_fields = 1'b1;
    end
    else
    begin
      case (state_q)
        time_digits:
        begin
          if (char_class == dec_digit && cnt_q < dec_max)
          begin
            load_time = 1'b1;
            cnt_d     = cnt_q + 1'b1;
          end
          else if (char_class == at_sign && cnt_q != '0)
          begin
            state_d = pc_digits;
            cnt_d   = '0;
          end
          else
            state_d = idle;
        end
        pc_digits:
        begin
          if (is_hex && cnt_q < hex_max)
          begin
            load_pc = 1'b1;
            cnt_d   = cnt_q + 1'b1;
          end
          else if (char_class == colon && cnt_q == hex_max)
          begin
            state_d = kind_select;
            cnt_d   = '0;
          end
          else
            state_d = idle;
        end
        kind_select:
        begin
          if (char_class == dollar || char_class == star)
          begin
            state_d  = target_field;
            is_mem_d = (char_class == star);
          end
          else if (char_class != space)
            state_d = idle;
        end
        target_field:
        begin
          if (target_digit && !spaced_q && cnt_q < target_max)
          begin
            load_reg  = !is_mem_q;
            load_addr = is_mem_q;
            cnt_d     = cnt_q + 1'b1;
          end
          else if (char_class == space && target_full)
            spaced_d = 1'b1;
          else if (char_class == less && target_full)
          begin
            state_d  = arrow_eq;
            cnt_d    = '0;
            spaced_d = 1'b0;
          end
          else
            state_d = idle;
        end
        arrow_eq:
        begin
          if (char_class == equal)
            state_d = data_digits;
          else
            state_d = idle;
        end
        data_digits:
        begin
          if (char_class == space && cnt_q == '0)
            state_d = data_digits; // spaces after <=
          else if (is_hex && cnt_q < hex_max)
            cnt_d = cnt_q + 1'b1; // data value only counted
          else if (char_class == hash && cnt_q == hex_max)
            state_d = reported;
          else
            state_d = idle;
        end
        default:
          state_d = idle; // idle and reported
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q  <= idle;
      cnt_q    <= '0;
      spaced_q <= 1'b0;
      is_mem_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      spaced_q <= spaced_d;
      is_mem_q <= is_mem_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (clear_fields)
    begin
      time_q <= '0;
      pc_q   <= '0;
      addr_q <= '0;
      reg_q  <= '0;
    end
    else
    begin
      if (load_time)
        time_q <= (time_q << 3) + (time_q << 1) + time_w'(digit_val); // x10 + d
      if (load_reg)
        reg_q <= (reg_q << 3) + (reg_q << 1) + reg_w'(digit_val);
      if (load_pc)
        pc_q <= {pc_q[word_w-5:0], digit_val};
      if (load_addr)
        addr_q <= {addr_q[word_w-5:0], digit_val};
    end
  end

  assign rec.done     = (state_q == reported);
  assign rec.is_mem   = is_mem_q;
  assign rec.time_val = time_q;
  assign rec.pc       = pc_q;
  assign rec.addr     = addr_q;
  assign rec.reg_num  = reg_q;

endmodule

// File: src/rule_checker.sv
module rule_checker
  import checker_pkg::*;
  import cfg_pkg::*;
(
  input  logic [time_w-1:0] freq,
  field_if.consumer         rec,
  output logic [1:0]        format_type,
  output logic [3:0]        error_code
);

  logic [time_w-1:0] half_freq;
  logic time_err;
  logic pc_err;
  logic addr_err;
  logic reg_err;
  format_e fmt;

  assign half_freq = freq >> 1;

  always_comb
  begin
    if (half_freq == '0)
      time_err = (rec.time_val != '0); // only time zero passes
    else
      time_err = ((rec.time_val % half_freq) != '0);
  end

  assign pc_err = (rec.pc[1:0] != 2'b00) || (rec.pc < text_lo) || (rec.pc > text_hi);

  assign addr_err = rec.is_mem && ((rec.addr[1:0] != 2'b00) || (rec.addr > data_hi));

  assign reg_err = !rec.is_mem && (rec.reg_num > reg_max);

  always_comb
  begin
    if (!rec.done)
      fmt = fmt_none;
    else if (rec.is_mem)
      fmt = fmt_mem;
    else
      fmt = fmt_reg;
  end

  assign format_type = fmt;
  assign error_code  = rec.done ? {reg_err, addr_err, pc_err, time_err} : 4'b0000;

endmodule

// File: verif/checker_trace.txt
// columns: freq (hex), expected format (0 none, 1 reg, 2 mem), expected error code (hex), text
// a leading + chains the text to the previous record, a reset line pulses reset
0a 1 0 ^10@00003000: $5 <= 0000abcd#
0a 1 0 ^25@00003004:   $31   <=   deadbeef#
64 1 0 ^1000@00004ffc:$0<=00000000#
0a 2 0 ^5@00003008: *00002ffc <= 12345678#
08 2 0 ^4@00003010: *00000000 <= ffffffff#
08 1 8 ^8@00003000: $40 <= 00000001#
08 2 4 ^8@00003000: *00003000 <= 00000001#
0a 1 1 ^7@00003000: $1 <= 00000001#
0a 1 2 ^5@00003002: $1 <= 00000001#
0a 2 2 ^5@00005000: *00000100 <= 00000001#
0a 2 4 ^5@00003000: *00000101 <= 00000001#
0a 1 8 ^5@00003000: $32 <= 00000001#
0a 2 7 ^7@00005001: *00003002 <= 00000001#
0a 1 b ^9@00003001: $32 <= 00000001#
01 1 0 ^0@00003000: $2 <= 00000002#
01 1 1 ^3@00003000: $2 <= 00000002#
0a 0 0 ^12345@00003000: $1 <= 00000001#
0a 0 0 ^5@0000300: $1 <= 00000001#
0a 0 0 ^5@00003000: *00000ABC <= 00000001#
0a 0 0 ^5@00003000: $1 < 00000001#
0a 0 0 ^5@00003000: $1 2 <= 00000001#
0a 0 0 ^5@00003000: $ <= 00000001#
0a 1 0 ^5@000030^10@00003000: $3 <= 00000003#
0a 2 0 ^5@00003000: *00000010 <= 0000^15@00003004: *00000020 <= 00000020#
0a 1 0 ^5@00003000: $1 <= 00000001#
0c 2 1 +^7@00003004: *00000008 <= 00000009#
0a 0 0 ^5@00003000: $1 <= 000
reset
0a 1 0 00001#^20@00003008: $7 <= 00000007#

// File: verif/tb_cpu_checker.sv
module tb_cpu_checker;

  timeunit 1ns;
  timeprecision 1ps;

  bit          clk;
  logic        reset;
  logic [15:0] freq;
  logic [7:0]  char;
  logic [1:0]  format_type;
  logic [3:0]  error_code;

  // trace entries, one per line of the file
  bit          line_reset[$]; // section break with reset
  bit          line_chain[$]; // record follows the previous one with no gap
  logic [15:0] line_freq[$];
  logic [1:0]  line_fmt[$];
  logic [3:0]  line_err[$];
  int          line_start[$];
  int          line_len[$];
  logic [7:0]  text[$];

  logic [1:0]  exp_fmt;
  logic [3:0]  exp_err;
  logic [1:0]  pend_fmt;  // report due in the next cycle
  logic [3:0]  pend_err;
  logic [15:0] pend_freq;
  bit          pend_valid;

  integer seed = 32'h2992;
  int     errors;
  int     cycle_cnt;
  int     cycle_limit;

  cpu_checker u_dut (
    .clk         (clk),
    .reset       (reset),
    .freq        (freq),
    .char        (char),
    .format_type (format_type),
    .error_code  (error_code)
  );

  initial
  begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit)
    begin
      $display("timeout: trace not finished");
      $display("=== FAIL ===");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // outputs are settled half a cycle after the edge
  always @(negedge clk)
  begin
    assert (format_type == exp_fmt && error_code == exp_err)
    else
    begin
      errors++;
      if (format_type !== exp_fmt)
        $display("mismatch at %0t: format_type expected %0d got %0d",
                 $time, exp_fmt, format_type);
      else
        $display("mismatch at %0t: error_code expected %h got %h",
                 $time, exp_err, error_code);
      $display("=== FAIL ===");
      $fatal(1, "output check failed");
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    exp_fmt <= pend_fmt;
    exp_err <= pend_err;
    if (pend_valid)
      freq <= pend_freq; // held through the report cycle
    pend_fmt   = 2'd0;
    pend_err   = 4'd0;
    pend_valid = 1'b0;
  endtask

  task automatic drive_char(input logic [7:0] c);
    next_cycle();
    char <= c;
  endtask

  task automatic pulse_reset();
    next_cycle();
    reset <= 1'b1; // char is left as it was
    next_cycle();
    next_cycle();
    reset <= 1'b0;
  endtask

  task automatic drive_fillers();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n)
      drive_char(8'("g" + $unsigned($random(seed)) % 20)); // g to z
  endtask

  task automatic load_trace(output bit ok);
    int         fd;
    int         c;
    int         fm;
    logic [3:0] e;
    string      tok;
    bit         chain;
    ok = 1'b1;
    fd = $fopen("verif/checker_trace.txt", "r");
    if (fd == 0)
      ok = 1'b0;
    else
    begin
      while ($fscanf(fd, "%s", tok) == 1)
      begin
        if (tok.len() >= 2 && tok.substr(0, 1) == "//")
        begin
          c = $fgetc(fd);
          while (c != "\n" && c != -1)
            c = $fgetc(fd);
        end
        else if (tok == "reset")
        begin
          line_reset.push_back(1'b1);
          line_chain.push_back(1'b0);
          line_freq.push_back(16'h0);
          line_fmt.push_back(2'd0);
          line_err.push_back(4'h0);
          line_start.push_back(text.size());
          line_len.push_back(0);
        end
        else if ($fscanf(fd, "%d %h", fm, e) != 2)
          ok = 1'b0;
        else
        begin
          line_reset.push_back(1'b0);
          line_freq.push_back(16'(tok.atohex()));
          line_fmt.push_back(fm[1:0]);
          line_err.push_back(e);
          line_start.push_back(text.size());
          c = $fgetc(fd);
          while (c == " ")
            c = $fgetc(fd);
          chain = (c == "+");
          if (chain)
            c = $fgetc(fd);
          while (c != "\n" && c != -1)
          begin
            if (c != 13)
              text.push_back(c[7:0]);
            c = $fgetc(fd);
          end
          line_chain.push_back(chain);
          line_len.push_back(text.size() - line_start[$]);
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    bit ok;
    reset      = 1'b1;
    freq       = 16'h0;
    char       = "z";
    exp_fmt    = 2'd0;
    exp_err    = 4'h0;
    pend_fmt   = 2'd0;
    pend_err   = 4'h0;
    pend_freq  = 16'h0;
    pend_valid = 1'b0;
    load_trace(ok);
    if (!ok || line_reset.size() == 0)
    begin
      $display("could not read the trace file verif/checker_trace.txt");
      $display("=== FAIL ===");
      $fatal(1, "trace file missing or malformed");
    end
    else
    begin
      cycle_limit = 2 + 4 + 20; // reset, flush and margin
      foreach (line_reset[i])
        cycle_limit += line_reset[i] ? 3 : line_len[i] + 3;
      next_cycle();
      next_cycle();
      reset <= 1'b0;
      for (int i = 0; i < line_reset.size(); i++)
      begin
        if (line_reset[i])
          pulse_reset();
        else
        begin
          for (int j = 0; j < line_len[i]; j++)
            drive_char(text[line_start[i] + j]);
          if (line_fmt[i] != 2'd0)
          begin
            pend_fmt   = line_fmt[i];
            pend_err   = line_err[i];
            pend_freq  = line_freq[i];
            pend_valid = 1'b1;
          end
          if (i + 1 == line_reset.size() || (!line_reset[i + 1] && !line_chain[i + 1]))
            drive_fillers();
        end
      end
      repeat (4)
        drive_char("z");
      if (errors == 0)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
      $finish;
    end
  end

endmodule
